// File: dv/usb_mem_bridge_properties.sv
`timescale 1ns/1ps
`default_nettype none

// Stream protocol checks on the bridge top level
module usb_mem_bridge_properties (
  input wire                          clock_i,
  input wire                          rst_n_i,
  input wire                          blki_tvalid_i,
  input wire                          blki_tready_i,
  input wire                          blki_tlast_i,
  input wire usb_mem_pkg::byte_t      blki_tdata_i,
  input wire                          rsp_tvalid_i,
  input wire                          rsp_tready_i,
  input wire                          rsp_tlast_i,
  input wire usb_mem_pkg::byte_t      rsp_tdata_i,
  input wire usb_mem_pkg::cmd_state_t state_i   // Engine FSM state
);

  blki_quiet_in_reset: assert property (@(posedge clock_i) !rst_n_i |=> !blki_tvalid_i)
    else $error("BULK IN valid high while in reset");

  // A stalled byte must not change
  blki_hold_when_stalled: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    (blki_tvalid_i && !blki_tready_i) |=>
      (blki_tvalid_i && $stable(blki_tdata_i) && $stable(blki_tlast_i)))
    else $error("BULK IN byte changed while stalled");

  rsp_hold_when_stalled: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    (rsp_tvalid_i && !rsp_tready_i) |=>
      (rsp_tvalid_i && $stable(rsp_tdata_i) && $stable(rsp_tlast_i)))
    else $error("Response byte changed while stalled");

  state_legal: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    state_i inside {usb_mem_pkg::ST_IDLE, usb_mem_pkg::ST_ADDR_HI, usb_mem_pkg::ST_ADDR_LO,
                    usb_mem_pkg::ST_LEN, usb_mem_pkg::ST_WR_DATA, usb_mem_pkg::ST_RD_ISSUE,
                    usb_mem_pkg::ST_RD_WAIT, usb_mem_pkg::ST_RD_SEND, usb_mem_pkg::ST_DROP})
    else $error("Command engine FSM in an illegal state");

endmodule

`default_nettype wire

// File: dv/usb_mem_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_mem_config.svh"

module usb_mem_bridge_tb;

  localparam int          NUM_ROWS       = 14;
  localparam int          TIMEOUT_CYCLES = 2000;
  localparam logic [31:0] SEED           = 32'd86306;

  typedef enum logic [2:0] {K_WRITE, K_READ, K_BAD, K_PRESS, K_CONC} kind_t;
  typedef struct packed {
    kind_t       kind;
    logic [7:0]  op;
    logic [15:0] addr;
    logic [8:0]  len;      // Data bytes, read length byte, or bytes of a bad packet
    logic [8:0]  exp_len;  // Expected response bytes
    logic        stall;    // Random BULK IN back-pressure
  } row_t;

  logic clock;
  logic rst_n;
  logic send_n;
  logic blko_tvalid;
  logic blko_tready;
  logic blko_tlast;
  usb_mem_pkg::byte_t blko_tdata;
  logic blki_tvalid;
  logic blki_tready;
  logic blki_tlast;
  usb_mem_pkg::byte_t blki_tdata;

  row_t               rows [NUM_ROWS];
  usb_mem_pkg::byte_t model_mem [`USB_MEM_SRAM_BYTES];
  int                 wr_cnt;
  int                 rd_cnt;
  int                 err_cnt;
  int                 errors;
  int                 timeouts;
  logic [31:0]        data_rng;
  logic [31:0]        stall_rng;
  logic               stall_en;
  logic [8:0]         rx_q [$];  // {last, data} seen on BULK IN
  usb_mem_pkg::byte_t got_q [$];
  usb_mem_pkg::byte_t first_q [$];
  usb_mem_pkg::byte_t exp_q [$];
  usb_mem_pkg::byte_t tlm_q [$];

  usb_mem_bridge_top i_usb_mem_bridge_top (
    .clock_i       (clock),
    .rst_n_i       (rst_n),
    .send_n_i      (send_n),
    .blko_tvalid_i (blko_tvalid),
    .blko_tready_o (blko_tready),
    .blko_tlast_i  (blko_tlast),
    .blko_tdata_i  (blko_tdata),
    .blki_tvalid_o (blki_tvalid),
    .blki_tready_i (blki_tready),
    .blki_tlast_o  (blki_tlast),
    .blki_tdata_o  (blki_tdata)
  );

  bind usb_mem_bridge_top usb_mem_bridge_properties i_usb_mem_bridge_properties (
    .clock_i       (clock_i),
    .rst_n_i       (rst_n_i),
    .blki_tvalid_i (blki_tvalid_o),
    .blki_tready_i (blki_tready_i),
    .blki_tlast_i  (blki_tlast_o),
    .blki_tdata_i  (blki_tdata_o),
    .rsp_tvalid_i  (rsp_tvalid),
    .rsp_tready_i  (rsp_tready),
    .rsp_tlast_i   (rsp_tlast),
    .rsp_tdata_i   (rsp_tdata),
    .state_i       (i_mem_cmd_engine.state_q)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // BULK IN sink drives ready after the edge and takes bytes before the next one
  initial begin
    forever begin
      @(posedge clock);
      #2;
      if (stall_en) begin
        stall_rng   = xorshift32(stall_rng);
        blki_tready = stall_rng[9];
      end else begin
        blki_tready = 1'b1;
      end
      @(negedge clock);
      if (blki_tvalid && blki_tready) rx_q.push_back({blki_tlast, blki_tdata});
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Only the low address bits count, and addresses wrap at the store size
  function automatic int wrap_addr(input logic [15:0] base, input int off);
    return (int'(base[`USB_MEM_ADDR_W-1:0]) + off) % `USB_MEM_SRAM_BYTES;
  endfunction

  function automatic usb_mem_pkg::byte_t sat8(input int cnt);
    return (cnt > 255) ? 8'd255 : cnt[7:0];
  endfunction

  task automatic load_table();
    rows[0]  = '{K_WRITE, `USB_MEM_OP_WRITE, 16'h0010, 9'd16,  9'd0,   1'b0};
    rows[1]  = '{K_READ,  `USB_MEM_OP_READ,  16'h0010, 9'd16,  9'd16,  1'b0};
    rows[2]  = '{K_PRESS, 8'h00,             16'h0000, 9'd0,   9'd4,   1'b0};
    rows[3]  = '{K_WRITE, `USB_MEM_OP_WRITE, 16'hF7F0, 9'd40,  9'd0,   1'b0};  // High bits ignored
    rows[4]  = '{K_READ,  `USB_MEM_OP_READ,  16'h07F0, 9'd40,  9'd40,  1'b1};
    rows[5]  = '{K_WRITE, `USB_MEM_OP_WRITE, 16'h0100, 9'd256, 9'd0,   1'b0};
    rows[6]  = '{K_READ,  `USB_MEM_OP_READ,  16'h0100, 9'd0,   9'd256, 1'b0};  // 0 means 256
    rows[7]  = '{K_BAD,   8'h33,             16'h0000, 9'd6,   9'd0,   1'b0};
    rows[8]  = '{K_BAD,   `USB_MEM_OP_READ,  16'h0020, 9'd3,   9'd0,   1'b0};
    rows[9]  = '{K_BAD,   `USB_MEM_OP_WRITE, 16'h0020, 9'd2,   9'd0,   1'b0};
    rows[10] = '{K_BAD,   8'h99,             16'h0000, 9'd1,   9'd0,   1'b0};
    rows[11] = '{K_PRESS, 8'h00,             16'h0000, 9'd0,   9'd4,   1'b1};
    rows[12] = '{K_READ,  `USB_MEM_OP_READ,  16'h0010, 9'd16,  9'd16,  1'b1};
    rows[13] = '{K_CONC,  `USB_MEM_OP_READ,  16'h0100, 9'd0,   9'd256, 1'b1};
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #2;
  endtask

  task automatic report_and_finish();
    $display("Summary: %0d errors, %0d timeouts", errors, timeouts);
    if ((errors == 0) && (timeouts == 0)) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  task automatic send_packet(input usb_mem_pkg::byte_t pkt [$]);
    int i;
    int waited;
    for (i = 0; i < pkt.size(); i++) begin
      blko_tvalid = 1'b1;
      blko_tdata  = pkt[i];
      blko_tlast  = (i == pkt.size() - 1);
      waited      = 0;
      @(negedge clock);
      while (!blko_tready) begin
        @(negedge clock);
        waited++;
        if (waited > TIMEOUT_CYCLES) begin
          $display("Timeout: BULK OUT byte %0d was never accepted", i);
          timeouts++;
          report_and_finish();
        end
      end
      next_cycle();
    end
    blko_tvalid = 1'b0;
    blko_tlast  = 1'b0;
  endtask

  // Gathers BULK IN bytes up to and including the next last
  task automatic collect_packet(input string what);
    int         waited;
    logic [8:0] ent;
    logic       done;
    got_q.delete();
    done = 1'b0;
    while (!done) begin
      waited = 0;
      while (rx_q.size() == 0) begin
        next_cycle();
        waited++;
        if (waited > TIMEOUT_CYCLES) begin
          $display("Timeout: the %s packet never arrived on BULK IN", what);
          timeouts++;
          report_and_finish();
        end
      end
      ent = rx_q.pop_front();
      got_q.push_back(ent[7:0]);
      done = ent[8] || (got_q.size() >= 300);
    end
  endtask

  task automatic compare_packet(input usb_mem_pkg::byte_t got [$],
                                input usb_mem_pkg::byte_t exp [$], input string what);
    int i;
    assert (got.size() == exp.size()) else begin
      $display("[FAIL] %0t: %s packet has %0d bytes, expected %0d",
               $time, what, got.size(), exp.size());
      errors++;
    end
    for (i = 0; (i < got.size()) && (i < exp.size()); i++) begin
      assert (got[i] == exp[i]) else begin
        $display("[FAIL] %0t: %s byte %0d is %02h, expected %02h",
                 $time, what, i, got[i], exp[i]);
        errors++;
      end
    end
  endtask

  task automatic do_write(input row_t row);
    usb_mem_pkg::byte_t pkt [$];
    int                 i;
    pkt.push_back(row.op);
    pkt.push_back(row.addr[15:8]);
    pkt.push_back(row.addr[7:0]);
    for (i = 0; i < row.len; i++) begin
      data_rng = xorshift32(data_rng);
      pkt.push_back(data_rng[7:0]);
      model_mem[wrap_addr(row.addr, i)] = data_rng[7:0];
    end
    send_packet(pkt);
    wr_cnt++;
  endtask

  task automatic send_read(input row_t row);
    usb_mem_pkg::byte_t pkt [$];
    int                 i;
    pkt.push_back(row.op);
    pkt.push_back(row.addr[15:8]);
    pkt.push_back(row.addr[7:0]);
    pkt.push_back(row.len[7:0]);
    exp_q.delete();
    for (i = 0; i < row.exp_len; i++) exp_q.push_back(model_mem[wrap_addr(row.addr, i)]);
    send_packet(pkt);
    // BULK OUT stays closed until the response has gone out
    assert (!blko_tready) else begin
      $display("[FAIL] %0t: BULK OUT ready high while a read response is pending", $time);
      errors++;
    end
  endtask

  // Expected bytes come from the model counters at the moment of the press
  task automatic press_button();
    tlm_q.delete();
    tlm_q.push_back(`USB_MEM_TELEM_MAGIC);
    tlm_q.push_back(sat8(wr_cnt));
    tlm_q.push_back(sat8(rd_cnt));
    tlm_q.push_back(sat8(err_cnt));
    send_n = 1'b0;
    repeat (4) next_cycle();
    send_n = 1'b1;
  endtask

  task automatic do_bad(input row_t row);
    usb_mem_pkg::byte_t full [$];
    usb_mem_pkg::byte_t pkt [$];
    int                 i;
    full.push_back(row.op);
    full.push_back(row.addr[15:8]);
    full.push_back(row.addr[7:0]);
    for (i = 0; i < 8; i++) full.push_back(8'hEE);
    for (i = 0; i < row.len; i++) pkt.push_back(full[i]);
    send_packet(pkt);
    err_cnt++;
    repeat (20) next_cycle();
    assert (rx_q.size() == 0) else begin
      $display("[FAIL] %0t: rejected packet produced %0d BULK IN bytes", $time, rx_q.size());
      errors++;
    end
  endtask

  initial begin
    int r;
    rst_n       = 1'b0;
    send_n      = 1'b1;
    blko_tvalid = 1'b0;
    blko_tlast  = 1'b0;
    blko_tdata  = 8'h00;
    blki_tready = 1'b1;
    stall_en    = 1'b0;
    data_rng    = SEED;
    stall_rng   = SEED;
    wr_cnt      = 0;
    rd_cnt      = 0;
    err_cnt     = 0;
    errors      = 0;
    timeouts    = 0;
    load_table();
    repeat (10) @(posedge clock);
    #2;
    rst_n = 1'b1;
    repeat (3) next_cycle();
    assert (blko_tready) else begin
      $display("[FAIL] %0t: BULK OUT ready low after reset", $time);
      errors++;
    end

    for (r = 0; r < NUM_ROWS; r++) begin
      stall_en = rows[r].stall;
      case (rows[r].kind)
        K_WRITE: do_write(rows[r]);
        K_READ: begin
          send_read(rows[r]);
          collect_packet("read");
          compare_packet(got_q, exp_q, "read");
          assert (blko_tready) else begin
            $display("[FAIL] %0t: BULK OUT ready low after the read response", $time);
            errors++;
          end
          rd_cnt++;
        end
        K_BAD: do_bad(rows[r]);
        K_PRESS: begin
          press_button();
          collect_packet("telemetry");
          compare_packet(got_q, tlm_q, "telemetry");
        end
        default: begin
          // Press while the long read response is still streaming
          send_read(rows[r]);
          repeat (10) next_cycle();
          press_button();
          collect_packet("first");
          first_q = got_q;
          collect_packet("second");
          if (first_q.size() == 4) begin
            compare_packet(first_q, tlm_q, "telemetry");
            compare_packet(got_q, exp_q, "read");
          end else begin
            compare_packet(first_q, exp_q, "read");
            compare_packet(got_q, tlm_q, "telemetry");
          end
          rd_cnt++;
        end
      endcase
    end

    stall_en = 1'b0;
    repeat (20) next_cycle();
    assert (rx_q.size() == 0) else begin
      $display("[FAIL] %0t: %0d unexpected BULK IN bytes at the end", $time, rx_q.size());
      errors++;
    end
    report_and_finish();
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f usb_mem_bridge.f \
  --top-module usb_mem_bridge_tb -Mdir obj_dir -o usb_mem_bridge_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/usb_mem_bridge_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "Everything OK" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0

// File: src/bulk_in_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

// Merges the response and telemetry streams into BULK IN, one whole packet at a time
module bulk_in_arbiter (
  input  wire                            clock_i,
  input  wire                            rst_n_i,

  input  wire                            rsp_tvalid_i,   // Read responses
  output logic                           rsp_tready_o,
  input  wire                            rsp_tlast_i,
  input  wire usb_mem_pkg::byte_t        rsp_tdata_i,

  input  wire                            tlm_tvalid_i,   // Telemetry packets
  output logic                           tlm_tready_o,
  input  wire                            tlm_tlast_i,
  input  wire usb_mem_pkg::byte_t        tlm_tdata_i,

  output logic                           blki_tvalid_o,  // To the USB core
  input  wire                            blki_tready_i,
  output logic                           blki_tlast_o,
  output usb_mem_pkg::byte_t             blki_tdata_o
);

  logic lock_q;      // Packet in progress or offered
  logic lock_tlm_q;  // Locked source is telemetry
  logic last_tlm_q;  // Telemetry finished the previous packet
  logic grant_tlm;
  logic blki_xfer;

  always_comb begin
    if (lock_q) begin
      grant_tlm = lock_tlm_q;
    end else if (rsp_tvalid_i && tlm_tvalid_i) begin
      grant_tlm = !last_tlm_q;  // Alternate on contention
    end else begin
      grant_tlm = tlm_tvalid_i;
    end
  end

  // Zero-latency forwarding of the granted source
  assign blki_tvalid_o = grant_tlm ? tlm_tvalid_i : rsp_tvalid_i;
  assign blki_tlast_o  = grant_tlm ? tlm_tlast_i  : rsp_tlast_i;
  assign blki_tdata_o  = grant_tlm ? tlm_tdata_i  : rsp_tdata_i;
  assign rsp_tready_o  = !grant_tlm && blki_tready_i;
  assign tlm_tready_o  = grant_tlm && blki_tready_i;
  assign blki_xfer     = blki_tvalid_o && blki_tready_i;

  // Hold the grant while a byte is offered, release on the transferred last byte
  always_ff @(posedge clock_i) begin
    if (!rst_n_i) begin
      lock_q     <= 1'b0;
      lock_tlm_q <= 1'b0;
      last_tlm_q <= 1'b0;
    end else if (blki_tvalid_o) begin
      if (blki_xfer && blki_tlast_o) begin
        lock_q     <= 1'b0;
        last_tlm_q <= grant_tlm;
      end else begin
        lock_q     <= 1'b1;
        lock_tlm_q <= grant_tlm;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/mem_cmd_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_mem_config.svh"

// Parses BULK OUT command packets, writes into the store and streams reads back
module mem_cmd_engine (
  input  wire                            clock_i,
  input  wire                            rst_n_i,

  // BULK OUT command stream
  input  wire                            blko_tvalid_i,
  output logic                           blko_tready_o,
  input  wire                            blko_tlast_i,
  input  wire usb_mem_pkg::byte_t        blko_tdata_i,

  // Read response stream
  output logic                           rsp_tvalid_o,
  input  wire                            rsp_tready_i,
  output logic                           rsp_tlast_o,
  output usb_mem_pkg::byte_t             rsp_tdata_o,

  // Byte store port
  output usb_mem_pkg::mem_addr_t         mem_addr_o,
  output logic                           mem_we_o,
  output usb_mem_pkg::byte_t             mem_wdata_o,
  input  wire usb_mem_pkg::byte_t        mem_rdata_i,

  // Single-cycle event strobes
  output logic                           wr_done_o,
  output logic                           rd_done_o,
  output logic                           cmd_err_o
);

  usb_mem_pkg::cmd_state_t state_q;
  logic                    is_rd_q;     // Header belongs to a read command
  logic                    len_seen_q;  // Length byte already taken
  logic                    wr_done_q;
  logic                    rd_done_q;
  logic                    err_q;

  usb_mem_pkg::byte_t      addr_hi_q;
  usb_mem_pkg::mem_addr_t  addr_q;      // Next byte to write or read
  logic [8:0]              rd_left_q;   // Response bytes still to send, 1 to 256
  usb_mem_pkg::byte_t      hold_q;      // Response holding register

  logic [15:0]             addr_full;
  logic                    op_known;
  logic                    out_acc;     // BULK OUT byte accepted this cycle
  logic                    rsp_xfer;    // Response byte transferred this cycle

  // No new command while a read response is pending
  assign blko_tready_o = (state_q != usb_mem_pkg::ST_RD_ISSUE) &&
                         (state_q != usb_mem_pkg::ST_RD_WAIT) &&
                         (state_q != usb_mem_pkg::ST_RD_SEND);

  assign out_acc   = blko_tvalid_i && blko_tready_o;
  assign addr_full = {addr_hi_q, blko_tdata_i};
  assign op_known  = (blko_tdata_i == `USB_MEM_OP_WRITE) || (blko_tdata_i == `USB_MEM_OP_READ);

  assign rsp_tvalid_o = (state_q == usb_mem_pkg::ST_RD_SEND);
  assign rsp_tlast_o  = rsp_tvalid_o && (rd_left_q == 9'd1);
  assign rsp_tdata_o  = hold_q;
  assign rsp_xfer     = rsp_tvalid_o && rsp_tready_i;

  // Next read address goes out in the transfer cycle, so one byte every two cycles
  assign mem_addr_o  = rsp_xfer ? addr_q + 1'b1 : addr_q;
  assign mem_we_o    = (state_q == usb_mem_pkg::ST_WR_DATA) && out_acc;
  assign mem_wdata_o = blko_tdata_i;

  assign wr_done_o = wr_done_q;
  assign rd_done_o = rd_done_q;
  assign cmd_err_o = err_q;

  always_ff @(posedge clock_i) begin
    if (!rst_n_i) begin
      state_q    <= usb_mem_pkg::ST_IDLE;
      is_rd_q    <= 1'b0;
      len_seen_q <= 1'b0;
      wr_done_q  <= 1'b0;
      rd_done_q  <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      wr_done_q <= 1'b0;
      rd_done_q <= 1'b0;
      err_q     <= 1'b0;
      case (state_q)
        usb_mem_pkg::ST_IDLE: if (out_acc) begin
          is_rd_q <= (blko_tdata_i == `USB_MEM_OP_READ);
          if (blko_tlast_i) begin
            err_q <= 1'b1;  // Opcode alone, or unknown opcode
          end else begin
            state_q <= op_known ? usb_mem_pkg::ST_ADDR_HI : usb_mem_pkg::ST_DROP;
          end
        end
        usb_mem_pkg::ST_ADDR_HI: if (out_acc) begin
          if (blko_tlast_i) begin
            err_q   <= 1'b1;
            state_q <= usb_mem_pkg::ST_IDLE;
          end else begin
            state_q <= usb_mem_pkg::ST_ADDR_LO;
          end
        end
        usb_mem_pkg::ST_ADDR_LO: if (out_acc) begin
          len_seen_q <= 1'b0;
          if (blko_tlast_i) begin
            // A bare write header is complete, a read still needs its length
            err_q     <= is_rd_q;
            wr_done_q <= !is_rd_q;
            state_q   <= usb_mem_pkg::ST_IDLE;
          end else begin
            state_q <= is_rd_q ? usb_mem_pkg::ST_LEN : usb_mem_pkg::ST_WR_DATA;
          end
        end
        usb_mem_pkg::ST_LEN: if (out_acc) begin
          len_seen_q <= 1'b1;
          if (blko_tlast_i) state_q <= usb_mem_pkg::ST_RD_ISSUE;
        end
        usb_mem_pkg::ST_WR_DATA: if (out_acc && blko_tlast_i) begin
          wr_done_q <= 1'b1;
          state_q   <= usb_mem_pkg::ST_IDLE;
        end
        usb_mem_pkg::ST_RD_ISSUE: state_q <= usb_mem_pkg::ST_RD_SEND;
        usb_mem_pkg::ST_RD_WAIT:  state_q <= usb_mem_pkg::ST_RD_SEND;
        usb_mem_pkg::ST_RD_SEND: if (rsp_xfer) begin
          if (rsp_tlast_o) begin
            rd_done_q <= 1'b1;
            state_q   <= usb_mem_pkg::ST_IDLE;
          end else begin
            state_q <= usb_mem_pkg::ST_RD_WAIT;
          end
        end
        usb_mem_pkg::ST_DROP: if (out_acc && blko_tlast_i) begin
          err_q   <= 1'b1;
          state_q <= usb_mem_pkg::ST_IDLE;
        end
        default: state_q <= usb_mem_pkg::ST_IDLE;
      endcase
    end
  end

  // Address, length and response data path
  always_ff @(posedge clock_i) begin
    if ((state_q == usb_mem_pkg::ST_ADDR_HI) && out_acc) addr_hi_q <= blko_tdata_i;
    if ((state_q == usb_mem_pkg::ST_ADDR_LO) && out_acc) begin
      addr_q <= addr_full[`USB_MEM_ADDR_W-1:0];  // Upper address bits ignored
    end
    if (mem_we_o || rsp_xfer) addr_q <= addr_q + 1'b1;  // Wraps at the store size

    if ((state_q == usb_mem_pkg::ST_LEN) && out_acc && !len_seen_q) begin
      rd_left_q <= (blko_tdata_i == 8'd0) ? 9'd256 : {1'b0, blko_tdata_i};
    end
    if (rsp_xfer) rd_left_q <= rd_left_q - 1'b1;

    if ((state_q == usb_mem_pkg::ST_RD_ISSUE) || (state_q == usb_mem_pkg::ST_RD_WAIT)) begin
      hold_q <= mem_rdata_i;
    end
  end

endmodule

`default_nettype wire

// File: src/sram_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_mem_config.svh"

// Single-port byte store with a registered read, in the manner of a block RAM
module sram_store (
  input  wire                            clock_i,

  input  wire usb_mem_pkg::mem_addr_t    addr_i,   // Shared read/write address
  input  wire                            we_i,
  input  wire usb_mem_pkg::byte_t        wdata_i,
  output usb_mem_pkg::byte_t             rdata_o   // Valid one cycle after addr_i
);

  usb_mem_pkg::byte_t mem_q [`USB_MEM_SRAM_BYTES];

  // Write port
  always_ff @(posedge clock_i) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // Read every cycle, old data on a simultaneous write
  always_ff @(posedge clock_i) begin
    rdata_o <= mem_q[addr_i];
  end

endmodule

`default_nettype wire

// File: src/telemetry_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_mem_config.svh"

// Counts engine events and sends a status packet when the button is pressed
module telemetry_gen (
  input  wire                            clock_i,
  input  wire                            rst_n_i,

  input  wire                            send_n_i,   // Active-low button, asynchronous
  input  wire                            wr_done_i,
  input  wire                            rd_done_i,
  input  wire                            cmd_err_i,

  output logic                           tlm_tvalid_o,
  input  wire                            tlm_tready_i,
  output logic                           tlm_tlast_o,
  output usb_mem_pkg::byte_t             tlm_tdata_o
);

  logic [1:0]          btn_sync_q;
  logic                btn_prev_q;
  logic                press;
  logic                tlm_xfer;

  usb_mem_pkg::count_t wr_cnt_q;
  usb_mem_pkg::count_t rd_cnt_q;
  usb_mem_pkg::count_t err_cnt_q;
  usb_mem_pkg::count_t wr_snap_q;
  usb_mem_pkg::count_t rd_snap_q;
  usb_mem_pkg::count_t err_snap_q;

  logic                busy_q;  // Packet pending
  logic [1:0]          wait_q;  // Cycles left before the packet is offered
  logic [1:0]          idx_q;   // Byte index within the packet

  function automatic usb_mem_pkg::count_t sat_inc(input usb_mem_pkg::count_t cnt,
                                                  input logic en);
    sat_inc = (en && (cnt != '1)) ? cnt + 1'b1 : cnt;
  endfunction

  assign press    = btn_prev_q && !btn_sync_q[1];  // Falling edge
  assign tlm_xfer = tlm_tvalid_o && tlm_tready_i;

  always_ff @(posedge clock_i) begin
    if (!rst_n_i) begin
      btn_sync_q <= 2'b11;  // Released
      btn_prev_q <= 1'b1;
      wr_cnt_q   <= '0;
      rd_cnt_q   <= '0;
      err_cnt_q  <= '0;
    end else begin
      btn_sync_q <= {btn_sync_q[0], send_n_i};
      btn_prev_q <= btn_sync_q[1];
      wr_cnt_q   <= sat_inc(wr_cnt_q, wr_done_i);
      rd_cnt_q   <= sat_inc(rd_cnt_q, rd_done_i);
      err_cnt_q  <= sat_inc(err_cnt_q, cmd_err_i);
    end
  end

  // Snapshot only when idle, so a pending packet keeps its bytes
  always_ff @(posedge clock_i) begin
    if (press && !busy_q) begin
      wr_snap_q  <= wr_cnt_q;
      rd_snap_q  <= rd_cnt_q;
      err_snap_q <= err_cnt_q;
    end
  end

  always_ff @(posedge clock_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      wait_q <= 2'd0;
      idx_q  <= 2'd0;
    end else if (!busy_q) begin
      if (press) begin
        busy_q <= 1'b1;
        wait_q <= 2'd2;
        idx_q  <= 2'd0;
      end
    end else if (wait_q != 2'd0) begin
      wait_q <= wait_q - 1'b1;
    end else if (tlm_xfer) begin
      if (tlm_tlast_o) busy_q <= 1'b0;
      idx_q <= idx_q + 1'b1;
    end
  end

  assign tlm_tvalid_o = busy_q && (wait_q == 2'd0);
  assign tlm_tlast_o  = tlm_tvalid_o && (idx_q == 2'd3);

  always_comb begin
    case (idx_q)
      2'd0:    tlm_tdata_o = `USB_MEM_TELEM_MAGIC;
      2'd1:    tlm_tdata_o = wr_snap_q;
      2'd2:    tlm_tdata_o = rd_snap_q;
      default: tlm_tdata_o = err_snap_q;
    endcase
  end

endmodule

`default_nettype wire

// File: src/usb_mem_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

// USB bulk to memory bridge, all on the USB bus clock
module usb_mem_bridge_top (
  input  wire                            clock_i,
  input  wire                            rst_n_i,
  input  wire                            send_n_i,       // Telemetry read-back button

  input  wire                            blko_tvalid_i,  // USB BULK OUT
  output logic                           blko_tready_o,
  input  wire                            blko_tlast_i,
  input  wire usb_mem_pkg::byte_t        blko_tdata_i,

  output logic                           blki_tvalid_o,  // USB BULK IN
  input  wire                            blki_tready_i,
  output logic                           blki_tlast_o,
  output usb_mem_pkg::byte_t             blki_tdata_o
);

  // Response and telemetry streams
  logic                   rsp_tvalid;
  logic                   rsp_tready;
  logic                   rsp_tlast;
  usb_mem_pkg::byte_t     rsp_tdata;
  logic                   tlm_tvalid;
  logic                   tlm_tready;
  logic                   tlm_tlast;
  usb_mem_pkg::byte_t     tlm_tdata;

  // Store port
  usb_mem_pkg::mem_addr_t mem_addr;
  logic                   mem_we;
  usb_mem_pkg::byte_t     mem_wdata;
  usb_mem_pkg::byte_t     mem_rdata;

  logic                   wr_done;
  logic                   rd_done;
  logic                   cmd_err;

  mem_cmd_engine i_mem_cmd_engine (
    .clock_i       (clock_i),
    .rst_n_i       (rst_n_i),
    .blko_tvalid_i (blko_tvalid_i),
    .blko_tready_o (blko_tready_o),
    .blko_tlast_i  (blko_tlast_i),
    .blko_tdata_i  (blko_tdata_i),
    .rsp_tvalid_o  (rsp_tvalid),
    .rsp_tready_i  (rsp_tready),
    .rsp_tlast_o   (rsp_tlast),
    .rsp_tdata_o   (rsp_tdata),
    .mem_addr_o    (mem_addr),
    .mem_we_o      (mem_we),
    .mem_wdata_o   (mem_wdata),
    .mem_rdata_i   (mem_rdata),
    .wr_done_o     (wr_done),
    .rd_done_o     (rd_done),
    .cmd_err_o     (cmd_err)
  );

  sram_store i_sram_store (  // Stands in for the DDR3 core
    .clock_i (clock_i),
    .addr_i  (mem_addr),
    .we_i    (mem_we),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

  telemetry_gen i_telemetry_gen (
    .clock_i      (clock_i),
    .rst_n_i      (rst_n_i),
    .send_n_i     (send_n_i),
    .wr_done_i    (wr_done),
    .rd_done_i    (rd_done),
    .cmd_err_i    (cmd_err),
    .tlm_tvalid_o (tlm_tvalid),
    .tlm_tready_i (tlm_tready),
    .tlm_tlast_o  (tlm_tlast),
    .tlm_tdata_o  (tlm_tdata)
  );

  bulk_in_arbiter i_bulk_in_arbiter (
    .clock_i       (clock_i),
    .rst_n_i       (rst_n_i),
    .rsp_tvalid_i  (rsp_tvalid),
    .rsp_tready_o  (rsp_tready),
    .rsp_tlast_i   (rsp_tlast),
    .rsp_tdata_i   (rsp_tdata),
    .tlm_tvalid_i  (tlm_tvalid),
    .tlm_tready_o  (tlm_tready),
    .tlm_tlast_i   (tlm_tlast),
    .tlm_tdata_i   (tlm_tdata),
    .blki_tvalid_o (blki_tvalid_o),
    .blki_tready_i (blki_tready_i),
    .blki_tlast_o  (blki_tlast_o),
    .blki_tdata_o  (blki_tdata_o)
  );

endmodule

`default_nettype wire

// File: src/usb_mem_config.svh
`ifndef USB_MEM_CONFIG_SVH
`define USB_MEM_CONFIG_SVH

// On-chip byte store standing in for the DDR3 core
`define USB_MEM_SRAM_BYTES 2048
`define USB_MEM_ADDR_W     11      // log2 of the store size

// Command opcodes, first byte of a BULK OUT packet
`define USB_MEM_OP_WRITE   8'h57   // ASCII 'W'
`define USB_MEM_OP_READ    8'h52   // ASCII 'R'

// Leading byte of every telemetry packet
`define USB_MEM_TELEM_MAGIC 8'hA7

`endif

// File: src/usb_mem_pkg.sv
`default_nettype none

`include "usb_mem_config.svh"

package usb_mem_pkg;

  typedef logic [7:0] byte_t;                       // Stream or memory byte
  typedef logic [`USB_MEM_ADDR_W-1:0] mem_addr_t;   // Byte address into the store
  typedef logic [7:0] count_t;                      // Saturating event count

  // Command engine states
  typedef enum logic [3:0] {
    ST_IDLE     = 4'd0,  // Waiting for an opcode
    ST_ADDR_HI  = 4'd1,
    ST_ADDR_LO  = 4'd2,
    ST_LEN      = 4'd3,  // Read length, trailing bytes ignored
    ST_WR_DATA  = 4'd4,
    ST_RD_ISSUE = 4'd5,  // First byte returning from the store
    ST_RD_WAIT  = 4'd6,  // Next byte returning from the store
    ST_RD_SEND  = 4'd7,
    ST_DROP     = 4'd8   // Discard up to tlast
  } cmd_state_t;

endpackage

`default_nettype wire

// File: usb_mem_bridge.f
+incdir+src
src/usb_mem_pkg.sv
src/sram_store.sv
src/mem_cmd_engine.sv
src/telemetry_gen.sv
src/bulk_in_arbiter.sv
src/usb_mem_bridge_top.sv
dv/usb_mem_bridge_properties.sv
dv/usb_mem_bridge_tb.sv
